//--- rtl/decode_consts.svh
// Widths, major opcode values and fixed constants of the decode stage.
// Include wherever one of these values is needed; the guard allows repeats.

`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define DEC_XLEN          64               // Register width
`define DEC_ILEN          32               // Instruction width
`define DEC_REG_ADDR_W    5                // Register address width
`define DEC_RESET_PC      64'h0000_0000_1000_0000 // PC after reset
`define DEC_REG_ZERO      5'd0             // Hard-wired zero register

// Major opcodes, bits [6:0] of the instruction
// ----------------------------------------
`define DEC_OPC_LOAD      7'b0000011
`define DEC_OPC_STORE     7'b0100011
`define DEC_OPC_BRANCH    7'b1100011
`define DEC_OPC_OP_IMM    7'b0010011
`define DEC_OPC_OP        7'b0110011
`define DEC_OPC_OP_IMM_W  7'b0011011
`define DEC_OPC_OP_W      7'b0111011
`define DEC_OPC_LUI       7'b0110111
`define DEC_OPC_AUIPC     7'b0010111
`define DEC_OPC_JAL       7'b1101111
`define DEC_OPC_JALR      7'b1100111

// ALU left operand sources
`define DEC_LHS_REG       2'd0             // rs1 data
`define DEC_LHS_PC        2'd1             // Program counter
`define DEC_LHS_ZERO      2'd2             // Constant zero

`endif

//--- rtl/decode_pkg.sv
// Operation codes and packed bundles shared by the decode stage units.
// Modules import it inside their bodies and use scoped names in headers.

`default_nettype none

`include "decode_consts.svh"

package decode_pkg;

    // Operation codes
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_NONE = 4'd0,
        LSU_LB   = 4'd1,
        LSU_LBU  = 4'd2,
        LSU_LH   = 4'd3,
        LSU_LHU  = 4'd4,
        LSU_LW   = 4'd5,
        LSU_LWU  = 4'd6,
        LSU_LD   = 4'd7,
        LSU_SB   = 4'd8,
        LSU_SH   = 4'd9,
        LSU_SW   = 4'd10,
        LSU_SD   = 4'd11
    } lsu_op_e;

    // Nine operations, so four bits
    typedef enum logic [3:0] {
        CFU_NONE = 4'd0,
        CFU_BEQ  = 4'd1,
        CFU_BNE  = 4'd2,
        CFU_BLT  = 4'd3,
        CFU_BGE  = 4'd4,
        CFU_BLTU = 4'd5,
        CFU_BGEU = 4'd6,
        CFU_JAL  = 4'd7,
        CFU_JALR = 4'd8
    } cfu_op_e;

    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_LSU  = 2'd2,
        WB_NPC  = 2'd3
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_S     = 3'd2,
        IMM_B     = 3'd3,
        IMM_U     = 3'd4,
        IMM_J     = 3'd5,
        IMM_SHAMT = 3'd6
    } imm_fmt_e;

    // Bundles
    // ----------------------------------------
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_word;    // Sign-extended 32-bit result
        lsu_op_e lsu_op;
        cfu_op_e cfu_op;
        wb_sel_e wb_sel;
        logic    trap;
    } uop_t;

    localparam uop_t UOP_NONE = '{
        alu_op: ALU_NONE, alu_word: 1'b0, lsu_op: LSU_NONE,
        cfu_op: CFU_NONE, wb_sel: WB_NONE, trap: 1'b0
    };

    typedef struct packed {
        logic [`DEC_XLEN-1:0]       pc;
        logic [`DEC_XLEN-1:0]       npc;
        logic [`DEC_XLEN-1:0]       imm;
        logic [`DEC_XLEN-1:0]       rs1_data;
        logic [`DEC_XLEN-1:0]       rs2_data;
        logic [`DEC_XLEN-1:0]       alu_lhs;
        logic [`DEC_XLEN-1:0]       alu_rhs;
        logic [`DEC_REG_ADDR_W-1:0] rs1_addr;
        logic [`DEC_REG_ADDR_W-1:0] rs2_addr;
        logic [`DEC_REG_ADDR_W-1:0] rd;
        logic [`DEC_ILEN-1:0]       instr;
        uop_t                       uop;
    } decoded_t;

endpackage

`default_nettype wire

//--- rtl/instr_classifier.sv
// Classifies a 32-bit RV64I instruction into ALU, LSU and CFU operations.
// Also picks the immediate format and operand sources for the other units.

`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module instr_classifier (
    input  logic [`DEC_ILEN-1:0] instr_i,
    output decode_pkg::uop_t     uop_o,
    output decode_pkg::imm_fmt_e imm_fmt_o,
    output logic [1:0]           lhs_sel_o,  // Register, PC or zero
    output logic                 rhs_imm_o,  // Right operand is the immediate
    output logic                 rd_none_o   // No register writeback
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    logic       f6_ok;        // Legal upper bits of a 64-bit shift
    logic       word_f3_ok;   // funct3 exists in the W forms
    logic       illegal;

    // ALU operation from funct3, with alt selecting SUB and SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign f7_zero    = (funct7 == 7'b0000000);
    assign f7_alt     = (funct7 == 7'b0100000);
    assign f6_ok      = (instr_i[31:26] == 6'b000000) ||
                        (instr_i[31:26] == 6'b010000 && funct3 == 3'b101);
    assign word_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        uop_o     = UOP_NONE;
        imm_fmt_o = IMM_NONE;
        lhs_sel_o = `DEC_LHS_REG;
        rhs_imm_o = 1'b0;
        rd_none_o = 1'b0;
        illegal   = 1'b0;

        case (opcode)
            `DEC_OPC_OP_IMM, `DEC_OPC_OP_IMM_W: begin
                uop_o.alu_op   = alu_from_funct3(funct3, funct3 == 3'b101 && instr_i[30]);
                uop_o.alu_word = (opcode == `DEC_OPC_OP_IMM_W);
                uop_o.wb_sel   = WB_ALU;
                rhs_imm_o      = 1'b1;
                imm_fmt_o      = (funct3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;
                if (opcode == `DEC_OPC_OP_IMM_W) begin
                    illegal = !word_f3_ok ||
                              (funct3 != 3'b000 && !f7_zero && !(f7_alt && funct3 == 3'b101));
                end else if (funct3[1:0] == 2'b01) begin
                    illegal = !f6_ok;
                end
            end
            `DEC_OPC_OP, `DEC_OPC_OP_W: begin
                uop_o.alu_op   = alu_from_funct3(funct3, instr_i[30]);
                uop_o.alu_word = (opcode == `DEC_OPC_OP_W);
                uop_o.wb_sel   = WB_ALU;
                illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) ||
                          (opcode == `DEC_OPC_OP_W && !word_f3_ok);
            end
            `DEC_OPC_LUI, `DEC_OPC_AUIPC: begin
                uop_o.alu_op = ALU_ADD;
                uop_o.wb_sel = WB_ALU;
                imm_fmt_o    = IMM_U;
                rhs_imm_o    = 1'b1;
                lhs_sel_o    = (opcode == `DEC_OPC_LUI) ? `DEC_LHS_ZERO : `DEC_LHS_PC;
            end
            `DEC_OPC_LOAD: begin
                uop_o.alu_op = ALU_ADD;                  // Address rs1 + imm
                uop_o.wb_sel = WB_LSU;
                imm_fmt_o    = IMM_I;
                rhs_imm_o    = 1'b1;
                case (funct3)
                    3'b000:  uop_o.lsu_op = LSU_LB;
                    3'b001:  uop_o.lsu_op = LSU_LH;
                    3'b010:  uop_o.lsu_op = LSU_LW;
                    3'b011:  uop_o.lsu_op = LSU_LD;
                    3'b100:  uop_o.lsu_op = LSU_LBU;
                    3'b101:  uop_o.lsu_op = LSU_LHU;
                    3'b110:  uop_o.lsu_op = LSU_LWU;
                    default: illegal      = 1'b1;
                endcase
            end
            `DEC_OPC_STORE: begin
                uop_o.alu_op = ALU_ADD;
                imm_fmt_o    = IMM_S;
                rhs_imm_o    = 1'b1;
                rd_none_o    = 1'b1;
                case (funct3)
                    3'b000:  uop_o.lsu_op = LSU_SB;
                    3'b001:  uop_o.lsu_op = LSU_SH;
                    3'b010:  uop_o.lsu_op = LSU_SW;
                    3'b011:  uop_o.lsu_op = LSU_SD;
                    default: illegal      = 1'b1;
                endcase
            end
            `DEC_OPC_BRANCH: begin
                uop_o.alu_op = ALU_SUB;                  // Compare rs1 - rs2
                imm_fmt_o    = IMM_B;
                rd_none_o    = 1'b1;
                case (funct3)
                    3'b000:  uop_o.cfu_op = CFU_BEQ;
                    3'b001:  uop_o.cfu_op = CFU_BNE;
                    3'b100:  uop_o.cfu_op = CFU_BLT;
                    3'b101:  uop_o.cfu_op = CFU_BGE;
                    3'b110:  uop_o.cfu_op = CFU_BLTU;
                    3'b111:  uop_o.cfu_op = CFU_BGEU;
                    default: illegal      = 1'b1;
                endcase
            end
            `DEC_OPC_JAL: begin
                uop_o.cfu_op = CFU_JAL;
                uop_o.wb_sel = WB_NPC;
                imm_fmt_o    = IMM_J;
                rhs_imm_o    = 1'b1;
            end
            `DEC_OPC_JALR: begin
                uop_o.cfu_op = CFU_JALR;
                uop_o.wb_sel = WB_NPC;
                imm_fmt_o    = IMM_I;
                rhs_imm_o    = 1'b1;
                illegal      = (funct3 != 3'b000);
            end
            default: illegal = 1'b1;
        endcase

        // Anything outside the decoded set becomes a bare trap
        if (illegal) begin
            uop_o      = UOP_NONE;
            uop_o.trap = 1'b1;
            imm_fmt_o  = IMM_NONE;
            lhs_sel_o  = `DEC_LHS_REG;
            rhs_imm_o  = 1'b0;
            rd_none_o  = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
// Immediate generator for the RV64I base formats.
// The classifier picks the format; the result is sign-extended to XLEN.

`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module imm_gen (
    input  logic [`DEC_ILEN-1:0] instr_i,
    input  decode_pkg::imm_fmt_e imm_fmt_i,
    output logic [`DEC_XLEN-1:0] imm_o
);
    import decode_pkg::*;

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (imm_fmt_i)
            IMM_I: begin
                imm_o = {{(`DEC_XLEN-12){sign}}, instr_i[31:20]};
            end
            IMM_S: begin
                imm_o = {{(`DEC_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{(`DEC_XLEN-13){sign}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {{(`DEC_XLEN-32){sign}}, instr_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{(`DEC_XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            IMM_SHAMT: begin
                imm_o = {{(`DEC_XLEN-6){1'b0}}, instr_i[25:20]};  // Zero-extended
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/operand_select.sv
// Register address extraction and ALU operand selection.
// Source controls come from the classifier, so no opcode is decoded here.

`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module operand_select (
    input  logic [`DEC_ILEN-1:0]       instr_i,
    input  logic [1:0]                 lhs_sel_i,
    input  logic                       rhs_imm_i,
    input  logic                       rd_none_i,
    input  logic [`DEC_XLEN-1:0]       imm_i,
    input  logic [`DEC_XLEN-1:0]       pc_i,
    input  logic [`DEC_XLEN-1:0]       rs1_data_i,
    input  logic [`DEC_XLEN-1:0]       rs2_data_i,
    output logic [`DEC_REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`DEC_REG_ADDR_W-1:0] rs2_addr_o,
    output logic [`DEC_REG_ADDR_W-1:0] rd_o,
    output logic [`DEC_XLEN-1:0]       alu_lhs_o,
    output logic [`DEC_XLEN-1:0]       alu_rhs_o
);

    // Register fields
    // ----------------------------------------
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_o       = rd_none_i ? `DEC_REG_ZERO : instr_i[11:7];  // Stores, branches, traps

    // ALU operands
    // ----------------------------------------
    always_comb begin
        case (lhs_sel_i)
            `DEC_LHS_PC:   alu_lhs_o = pc_i;        // AUIPC
            `DEC_LHS_ZERO: alu_lhs_o = '0;          // LUI
            default:       alu_lhs_o = rs1_data_i;
        endcase
    end

    assign alu_rhs_o = rhs_imm_i ? imm_i : rs2_data_i;

endmodule

`default_nettype wire

//--- rtl/pc_tracker.sv
// Program counter of the decode stage.
// Advances by one instruction on a consume; a redirect overrides it.

`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module pc_tracker #(
    parameter logic [`DEC_XLEN-1:0] RESET_PC = `DEC_RESET_PC
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 eat_i,        // Instruction consumed
    input  logic                 cf_valid_i,
    input  logic                 cf_ack_i,
    input  logic [`DEC_XLEN-1:0] cf_target_i,
    output logic [`DEC_XLEN-1:0] pc_o,
    output logic [`DEC_XLEN-1:0] npc_o
);

    logic redirect;

    assign redirect = cf_valid_i && cf_ack_i;
    assign npc_o    = pc_o + `DEC_XLEN'd4;     // 32-bit instructions only

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_o <= RESET_PC;
        end else if (redirect) begin
            pc_o <= cf_target_i;               // Wins over a consume
        end else if (eat_i) begin
            pc_o <= npc_o;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
// Decode and operand-gather stage of the RV64I pipeline, top level.
// Combinational from fetch to execute; only the PC is registered.
// Register reads go out and return forwarded data in the same cycle.

`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_stage #(
    parameter logic [`DEC_XLEN-1:0] RESET_PC = `DEC_RESET_PC
) (
    input  logic                       g_clk,
    input  logic                       g_resetn,

    input  logic                       fetch_valid_i,
    input  logic [`DEC_ILEN-1:0]       fetch_instr_i,
    output logic                       fetch_eat_o,    // Fetch drops the word

    input  logic                       cf_valid_i,
    input  logic                       cf_ack_i,
    input  logic [`DEC_XLEN-1:0]       cf_target_i,

    output logic [`DEC_REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`DEC_REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [`DEC_XLEN-1:0]       rs1_data_i,     // Forwarded
    input  logic [`DEC_XLEN-1:0]       rs2_data_i,

    input  logic                       s2_ready_i,
    output logic                       s2_valid_o,
    output decode_pkg::decoded_t       s2_o
);
    import decode_pkg::*;

    uop_t                       uop;
    imm_fmt_e                   imm_fmt;
    logic [1:0]                 lhs_sel;
    logic                       rhs_imm;
    logic                       rd_none;
    logic [`DEC_XLEN-1:0]       imm;
    logic [`DEC_XLEN-1:0]       pc;
    logic [`DEC_XLEN-1:0]       npc;
    logic [`DEC_REG_ADDR_W-1:0] rd;
    logic [`DEC_XLEN-1:0]       alu_lhs;
    logic [`DEC_XLEN-1:0]       alu_rhs;

    // Handshake
    // ----------------------------------------
    assign s2_valid_o  = fetch_valid_i;
    assign fetch_eat_o = fetch_valid_i && s2_ready_i;

    // Units
    // ----------------------------------------
    instr_classifier i_instr_classifier (
        .instr_i   (fetch_instr_i),
        .uop_o     (uop),
        .imm_fmt_o (imm_fmt),
        .lhs_sel_o (lhs_sel),
        .rhs_imm_o (rhs_imm),
        .rd_none_o (rd_none)
    );

    imm_gen i_imm_gen (
        .instr_i   (fetch_instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    operand_select i_operand_select (
        .instr_i    (fetch_instr_i),
        .lhs_sel_i  (lhs_sel),
        .rhs_imm_i  (rhs_imm),
        .rd_none_i  (rd_none),
        .imm_i      (imm),
        .pc_i       (pc),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_o       (rd),
        .alu_lhs_o  (alu_lhs),
        .alu_rhs_o  (alu_rhs)
    );

    pc_tracker #(
        .RESET_PC (RESET_PC)
    ) i_pc_tracker (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .eat_i       (fetch_eat_o),
        .cf_valid_i  (cf_valid_i),
        .cf_ack_i    (cf_ack_i),
        .cf_target_i (cf_target_i),
        .pc_o        (pc),
        .npc_o       (npc)
    );

    // Bundle to execute
    // ----------------------------------------
    assign s2_o.pc       = pc;
    assign s2_o.npc      = npc;
    assign s2_o.imm      = imm;
    assign s2_o.rs1_data = rs1_data_i;
    assign s2_o.rs2_data = rs2_data_i;
    assign s2_o.alu_lhs  = alu_lhs;
    assign s2_o.alu_rhs  = alu_rhs;
    assign s2_o.rs1_addr = rs1_addr_o;
    assign s2_o.rs2_addr = rs2_addr_o;
    assign s2_o.rd       = rd;
    assign s2_o.instr    = fetch_instr_i;
    assign s2_o.uop      = uop;

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// Clock and reset source for the decode stage testbench.
// g_clk runs with a 4 ns period; g_resetn stays low for RESET_CYCLES rising edges.

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic g_clk_o,
    output logic g_resetn_o
);

    initial begin
        g_clk_o = 1'b0;
        forever #2 g_clk_o = ~g_clk_o;   // 4 ns period
    end

    initial begin
        g_resetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk_o);
        @(negedge g_clk_o);              // Release on a falling edge
        g_resetn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_decode_stage.sv
// Self-checking testbench for the decode stage.
// Reads tests/decode_tests.txt, drives one vector per cycle on the falling edge
// and checks the stage-2 bundle, the handshake and a modelled PC before the rising edge.

`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module tb_decode_stage;
    import decode_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_VECTORS  = 256;
    localparam int MARGIN       = 50;

    // One line of the vector file
    typedef struct packed {
        logic [7:0]  kind;       // v decode, a AUIPC, i fetch idle
        logic [31:0] instr;
        logic [63:0] rs1_data;
        logic [63:0] rs2_data;
        logic        ready;
        logic        cf_valid;
        logic        cf_ack;
        logic [63:0] cf_target;
        logic [4:0]  rd;
        logic [63:0] imm;
        logic [63:0] alu_lhs;
        logic [63:0] alu_rhs;
        logic [3:0]  alu_op;
        logic        alu_word;
        logic [3:0]  lsu_op;
        logic [3:0]  cfu_op;
        logic [1:0]  wb_sel;
        logic        trap;
    } vector_t;

    logic        g_clk;
    logic        g_resetn;
    logic        fetch_valid;
    logic [31:0] fetch_instr;
    logic        fetch_eat;
    logic        cf_valid;
    logic        cf_ack;
    logic [63:0] cf_target;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    logic        s2_ready;
    logic        s2_valid;
    decoded_t    s2;

    vector_t     vecs [0:MAX_VECTORS-1];
    int          num_vectors;
    int          cur_vec;
    int          errors;
    int          cycles;
    int          cycle_limit;
    logic [63:0] pc_model;       // Expected PC of the current vector

    tb_clock_gen #(
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock_gen (
        .g_clk_o    (g_clk),
        .g_resetn_o (g_resetn)
    );

    decode_stage #(
        .RESET_PC (`DEC_RESET_PC)
    ) i_dut (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .fetch_valid_i (fetch_valid),
        .fetch_instr_i (fetch_instr),
        .fetch_eat_o   (fetch_eat),
        .cf_valid_i    (cf_valid),
        .cf_ack_i      (cf_ack),
        .cf_target_i   (cf_target),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .s2_ready_i    (s2_ready),
        .s2_valid_o    (s2_valid),
        .s2_o          (s2)
    );

    // Helpers
    // ----------------------------------------
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("CHECK FAILED vector %0d %s got 0x%h expected 0x%h", cur_vec, name, got, exp);
    endtask

    task automatic load_vectors();
        int               fd;
        int               c;
        int               got;
        logic [8*256-1:0] rest;
        logic [63:0]      instr_f, rs1_f, rs2_f, rdy_f, cfv_f, cfa_f, target_f, rd_f;
        logic [63:0]      imm_f, lhs_f, rhs_f, alu_f, word_f, lsu_f, cfu_f, wb_f, trap_f;
        vector_t          v;
        num_vectors = 0;
        fd = $fopen("tests/decode_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vector file tests/decode_tests.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    got = $fgets(rest, fd);                     // Column description
                end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                    got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  instr_f, rs1_f, rs2_f, rdy_f, cfv_f, cfa_f, target_f,
                                  rd_f, imm_f, lhs_f, rhs_f, alu_f, word_f, lsu_f,
                                  cfu_f, wb_f, trap_f);
                    if (got != 17 || num_vectors >= MAX_VECTORS) begin
                        errors++;
                        $display("Bad or surplus vector line after vector %0d", num_vectors);
                        got = $fgets(rest, fd);
                    end else begin
                        v.kind      = c[7:0];
                        v.instr     = instr_f[31:0];
                        v.rs1_data  = rs1_f;
                        v.rs2_data  = rs2_f;
                        v.ready     = rdy_f[0];
                        v.cf_valid  = cfv_f[0];
                        v.cf_ack    = cfa_f[0];
                        v.cf_target = target_f;
                        v.rd        = rd_f[4:0];
                        v.imm       = imm_f;
                        v.alu_lhs   = lhs_f;
                        v.alu_rhs   = rhs_f;
                        v.alu_op    = alu_f[3:0];
                        v.alu_word  = word_f[0];
                        v.lsu_op    = lsu_f[3:0];
                        v.cfu_op    = cfu_f[3:0];
                        v.wb_sel    = wb_f[1:0];
                        v.trap      = trap_f[0];
                        vecs[num_vectors] = v;
                        num_vectors++;
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vector(input vector_t v);
        fetch_valid = (v.kind != "i");
        fetch_instr = v.instr;
        rs1_data    = v.rs1_data;
        rs2_data    = v.rs2_data;
        s2_ready    = v.ready;
        cf_valid    = v.cf_valid;
        cf_ack      = v.cf_ack;
        cf_target   = v.cf_target;
    endtask

    task automatic check_vector(input vector_t v, input logic [63:0] exp_pc);
        logic        valid;
        logic        exp_eat;
        logic [63:0] exp_lhs;
        valid   = (v.kind != "i");
        exp_eat = valid && v.ready;
        exp_lhs = (v.kind == "a") ? exp_pc : v.alu_lhs;    // AUIPC adds the PC
        if (s2_valid !== valid) report_mismatch("s2_valid_o", s2_valid, valid);
        if (fetch_eat !== exp_eat) report_mismatch("fetch_eat_o", fetch_eat, exp_eat);
        if (rs1_addr !== v.instr[19:15]) report_mismatch("rs1_addr_o", rs1_addr, v.instr[19:15]);
        if (rs2_addr !== v.instr[24:20]) report_mismatch("rs2_addr_o", rs2_addr, v.instr[24:20]);
        if (s2.rs1_addr !== v.instr[19:15]) report_mismatch("s2_o.rs1_addr", s2.rs1_addr,
                                                            v.instr[19:15]);
        if (s2.rs2_addr !== v.instr[24:20]) report_mismatch("s2_o.rs2_addr", s2.rs2_addr,
                                                            v.instr[24:20]);
        if (s2.instr !== v.instr) report_mismatch("s2_o.instr", s2.instr, v.instr);
        if (s2.rs1_data !== v.rs1_data) report_mismatch("s2_o.rs1_data", s2.rs1_data, v.rs1_data);
        if (s2.rs2_data !== v.rs2_data) report_mismatch("s2_o.rs2_data", s2.rs2_data, v.rs2_data);
        if (s2.pc !== exp_pc) report_mismatch("s2_o.pc", s2.pc, exp_pc);
        if (s2.npc !== exp_pc + 64'd4) report_mismatch("s2_o.npc", s2.npc, exp_pc + 64'd4);
        if (s2.rd !== v.rd) report_mismatch("s2_o.rd", s2.rd, v.rd);
        if (s2.imm !== v.imm) report_mismatch("s2_o.imm", s2.imm, v.imm);
        if (s2.alu_lhs !== exp_lhs) report_mismatch("s2_o.alu_lhs", s2.alu_lhs, exp_lhs);
        if (s2.alu_rhs !== v.alu_rhs) report_mismatch("s2_o.alu_rhs", s2.alu_rhs, v.alu_rhs);
        if (s2.uop.alu_op !== v.alu_op) report_mismatch("s2_o.uop.alu_op", s2.uop.alu_op, v.alu_op);
        if (s2.uop.alu_word !== v.alu_word) report_mismatch("s2_o.uop.alu_word", s2.uop.alu_word,
                                                            v.alu_word);
        if (s2.uop.lsu_op !== v.lsu_op) report_mismatch("s2_o.uop.lsu_op", s2.uop.lsu_op, v.lsu_op);
        if (s2.uop.cfu_op !== v.cfu_op) report_mismatch("s2_o.uop.cfu_op", s2.uop.cfu_op, v.cfu_op);
        if (s2.uop.wb_sel !== v.wb_sel) report_mismatch("s2_o.uop.wb_sel", s2.uop.wb_sel, v.wb_sel);
        if (s2.uop.trap !== v.trap) report_mismatch("s2_o.uop.trap", s2.uop.trap, v.trap);
    endtask

    // PC after the rising edge that ends this vector
    function automatic logic [63:0] next_pc(input vector_t v, input logic [63:0] pc);
        if (v.cf_valid && v.cf_ack) begin
            return v.cf_target;                    // Redirect wins
        end else if (v.kind != "i" && v.ready) begin
            return pc + 64'd4;
        end
        return pc;
    endfunction

    // Run limit
    // ----------------------------------------
    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the vector loop did not finish", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Main sequence
    // ----------------------------------------
    initial begin
        errors      = 0;
        cycles      = 0;
        cur_vec     = 0;
        cycle_limit = RESET_CYCLES + MARGIN;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        s2_ready    = 1'b0;
        cf_valid    = 1'b0;
        cf_ack      = 1'b0;
        cf_target   = '0;
        pc_model    = `DEC_RESET_PC;

        load_vectors();
        cycle_limit = num_vectors + RESET_CYCLES + MARGIN;
        if (num_vectors == 0 && errors == 0) begin
            errors++;
            $display("The vector file holds no vectors");
        end

        wait (g_resetn === 1'b1);
        for (cur_vec = 0; cur_vec < num_vectors; cur_vec++) begin
            @(negedge g_clk);
            apply_vector(vecs[cur_vec]);
            #1;                                    // Midway to the rising edge
            check_vector(vecs[cur_vec], pc_model);
            pc_model = next_pc(vecs[cur_vec], pc_model);
        end

        @(negedge g_clk);
        fetch_valid = 1'b0;
        cf_valid    = 1'b0;
        cf_ack      = 1'b0;

        $display("Vectors run: %0d, errors: %0d", num_vectors, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/decode_tests.txt
# kind instr rs1_data rs2_data ready cf_valid cf_ack cf_target, then expected rd imm alu_lhs
# alu_rhs alu_op alu_word lsu_op cfu_op wb_sel trap; kind v decode, a AUIPC (lhs = PC), i idle
v 002081b3 10 22 1 0 0 0 3 0 10 22 1 0 0 0 1 0
v 402081b3 10 22 1 0 0 0 3 0 10 22 2 0 0 0 1 0
v 4020d1b3 10 22 1 0 0 0 3 0 10 22 8 0 0 0 1 0
v 002081bb 10 22 1 0 0 0 3 0 10 22 1 1 0 0 1 0
v 402081bb 10 22 1 0 0 0 3 0 10 22 2 1 0 0 1 0
v ff008193 10 22 1 0 0 0 3 fffffffffffffff0 10 fffffffffffffff0 1 0 0 0 1 0
v 02109193 10 22 1 0 0 0 3 21 10 21 6 0 0 0 1 0
v 4050d193 10 22 1 0 0 0 3 5 10 5 8 0 0 0 1 0
v 0070819b 10 22 1 0 0 0 3 7 10 7 1 1 0 0 1 0
v 0010b193 10 22 1 0 0 0 3 1 10 1 a 0 0 0 1 0
v ff80b183 10 22 1 0 0 0 3 fffffffffffffff8 10 fffffffffffffff8 1 0 7 0 2 0
v 0040c183 10 22 1 0 0 0 3 4 10 4 1 0 2 0 2 0
v fe20be23 10 22 1 0 0 0 0 fffffffffffffffc 10 fffffffffffffffc 1 0 b 0 0 0
v 002084a3 10 22 1 0 0 0 0 9 10 9 1 0 8 0 0 0
v 00208863 10 22 1 0 0 0 0 10 10 22 2 0 0 1 0 0
v fe20ece3 10 22 1 0 0 0 0 fffffffffffffff8 10 22 2 0 0 5 0 0
v 001000ef 10 22 1 0 0 0 1 800 10 800 0 0 0 7 3 0
v 00c280e7 10 22 1 0 0 0 1 c 10 c 0 0 0 8 3 0
v 123451b7 10 22 1 0 0 0 3 12345000 0 12345000 1 0 0 0 1 0
v 800001b7 10 22 1 0 0 0 3 ffffffff80000000 0 ffffffff80000000 1 0 0 0 1 0
a 00001197 10 22 1 0 0 0 3 1000 0 1000 1 0 0 0 1 0
v 002081b3 10 22 0 0 0 0 3 0 10 22 1 0 0 0 1 0
a 00001197 10 22 1 0 0 0 3 1000 0 1000 1 0 0 0 1 0
i 002081b3 10 22 1 0 0 0 3 0 10 22 1 0 0 0 1 0
v 001000ef 10 22 1 1 1 20000100 1 800 10 800 0 0 0 7 3 0
a 00001197 10 22 1 1 0 30000000 3 1000 0 1000 1 0 0 0 1 0
a 00001197 10 22 1 0 0 0 3 1000 0 1000 1 0 0 0 1 0
v 000001ff 10 22 1 0 0 0 0 0 10 22 0 0 0 0 0 1
v 022081b3 10 22 1 0 0 0 0 0 10 22 0 0 0 0 0 1
v 0000f183 10 22 1 0 0 0 0 0 10 22 0 0 0 0 0 1

//--- sources.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/instr_classifier.sv
rtl/imm_gen.sv
rtl/operand_select.sv
rtl/pc_tracker.sv
rtl/decode_stage.sv
tests/tb_clock_gen.sv
tests/tb_decode_stage.sv

//--- Bender.yml
package:
  name: rv64_decode_stage

export_include_dirs:
  - rtl

sources:
  - rtl/decode_pkg.sv
  - rtl/instr_classifier.sv
  - rtl/imm_gen.sv
  - rtl/operand_select.sv
  - rtl/pc_tracker.sv
  - rtl/decode_stage.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_decode_stage.sv
